// File: list.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
common/core_ifs.sv
exec/exec_timer.sv
exec/add_unit.sv
station/res_station.sv
verilog/reg_file.sv
verilog/issue_ctrl.sv
verilog/tomasulo_core.sv
bench/core_chk.sv
bench/tb_tomasulo_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the add core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tomasulo_core -Mdir obj_dir -o sim_tb -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: bench/tb_tomasulo_core.sv
// testbench for the add core with clock, reset, directed tests,
// compare tasks, bus monitor and closing report
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module tb_tomasulo_core import isa_pkg::*, core_pkg::*; ();

  // cycles any single wait may take before it gives up
  localparam int TIMEOUT = 200;

  logic     clk;
  logic     rst_n;
  logic     instr_req;
  instr_t   instr;
  logic     instr_ack;
  logic     cdb_valid;
  reg_idx_t cdb_dest;
  data_t    cdb_data;
  reg_idx_t dbg_sel;
  data_t    dbg_data;

  // architectural state in program order
  data_t    model [`NUM_REGS];
  // broadcasts still pending, one per issued add
  reg_idx_t exp_dest [$];
  data_t    exp_data [$];
  // broadcasts seen on the bus in arrival order
  reg_idx_t seen_dest [$];
  data_t    seen_data [$];
  int       err_count;
  int       timeout_count;
  int       check_count;

  tomasulo_core tomasulo_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .cdb_valid (cdb_valid),
    .cdb_dest  (cdb_dest),
    .cdb_data  (cdb_data),
    .dbg_sel   (dbg_sel),
    .dbg_data  (dbg_data)
  );

  always #5 clk = ~clk;

  // bus monitor samples mid-cycle where the pulse is stable
  always @(negedge clk) begin
    if (rst_n && cdb_valid) begin
      seen_dest.push_back(cdb_dest);
      seen_data.push_back(cdb_data);
    end
  end

  // op[11:9] dest[8:6] src_a[5:3] src_b[2:0]
  function automatic instr_t make_instr(opcode_t op, reg_idx_t d, reg_idx_t a, reg_idx_t b);
    return {op, d, a, b};
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_data(data_t got, data_t exp, string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(reg_idx_t got, reg_idx_t exp, string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: %s got r%0d expected r%0d", $time, what, got, exp);
    end
  endtask

  // four-phase handshake that raises req, waits for ack, drops req and waits for ack low
  task automatic issue_instr(instr_t word);
    int n;
    instr = word;
    instr_req = 1'b1;
    n = 0;
    while (instr_ack !== 1'b1 && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (instr_ack !== 1'b1) begin
      timeout_count++;
      $display("timeout: instruction %h was never acknowledged at %0t", word, $time);
    end
    instr_req = 1'b0;
    n = 0;
    while (instr_ack !== 1'b0 && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (instr_ack !== 1'b0) begin
      timeout_count++;
      $display("timeout: ack stayed high after the request fell at %0t", $time);
    end
  endtask

  // sequential sum from the model where r0 never takes a value
  task automatic issue_add(reg_idx_t d, reg_idx_t a, reg_idx_t b);
    data_t sum;
    sum = model[a] + model[b];
    exp_dest.push_back(d);
    exp_data.push_back(sum);
    if (d != '0) model[d] = sum;
    issue_instr(make_instr(ADDF, d, a, b));
  endtask

  // next broadcast from the monitor
  task automatic wait_cdb(output reg_idx_t dest, output data_t data);
    int n;
    dest = '0;
    data = '0;
    n = 0;
    while (seen_dest.size() == 0 && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (seen_dest.size() == 0) begin
      timeout_count++;
      $display("timeout: no broadcast on the common data bus at %0t", $time);
    end else begin
      dest = seen_dest.pop_front();
      data = seen_data.pop_front();
    end
  endtask

  // results leave the unit out of order, so each broadcast is matched by destination
  task automatic drain_cdb();
    reg_idx_t d;
    data_t    v;
    int       hit;
    while (exp_dest.size() != 0) begin
      wait_cdb(d, v);
      hit = -1;
      for (int j = 0; j < exp_dest.size(); j++) begin
        if (hit < 0 && exp_dest[j] == d) hit = j;
      end
      // an unknown destination is compared with the oldest pending one
      if (hit < 0) hit = 0;
      check_reg(d, exp_dest[hit], "broadcast dest");
      check_data(v, exp_data[hit], "broadcast data");
      exp_dest.delete(hit);
      exp_data.delete(hit);
    end
  endtask

  task automatic read_reg(reg_idx_t idx, output data_t val);
    dbg_sel = idx;
    next_cycle();
    val = dbg_data;
  endtask

  task automatic check_all_regs();
    data_t v;
    for (int i = 0; i < `NUM_REGS; i++) begin
      read_reg(reg_idx_t'(i), v);
      check_data(v, model[i], $sformatf("r%0d", i));
    end
  endtask

  task automatic test_ignored_opcodes();
    opcode_t ops [4];
    int n;
    ops[0] = NOP;
    ops[1] = LD;
    ops[2] = ST;
    ops[3] = MULTF;
    foreach (ops[k]) begin
      issue_instr(make_instr(ops[k], 3'd5, 3'd1, 3'd2));
      // quiet window of twice the add latency
      n = 0;
      while (n < 2 * `ADD_LATENCY) begin
        next_cycle();
        n++;
      end
      if (seen_dest.size() != 0) begin
        err_count++;
        $display("opcode %s caused a broadcast at %0t", ops[k].name(), $time);
        seen_dest.delete();
        seen_data.delete();
      end
      check_all_regs();
    end
  endtask

  // chain r2 to r3 to r4 and then adds that each wait on r4
  task automatic test_back_pressure();
    issue_add(3'd2, 3'd1, 3'd1);
    issue_add(3'd3, 3'd2, 3'd2);
    issue_add(3'd4, 3'd3, 3'd3);
    issue_add(3'd5, 3'd4, 3'd1);
    issue_add(3'd6, 3'd4, 3'd2);
    issue_add(3'd7, 3'd1, 3'd4);
    drain_cdb();
    check_all_regs();
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    instr_req = 1'b0;
    instr = '0;
    dbg_sel = '0;
    err_count = 0;
    timeout_count = 0;
    check_count = 0;
    model[0] = '0;
    for (int i = 1; i < `NUM_REGS; i++) model[i] = data_t'(`REG_RESET_VAL);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    // reset values
    check_all_regs();
    // single add
    issue_add(3'd2, 3'd1, 3'd1);
    drain_cdb();
    check_all_regs();
    // dependent pair where r3 captures r2 from the bus
    issue_add(3'd2, 3'd1, 3'd1);
    issue_add(3'd3, 3'd2, 3'd1);
    drain_cdb();
    check_all_regs();
    test_ignored_opcodes();
    test_back_pressure();
    // r0 as destination still broadcasts
    issue_add(3'd0, 3'd1, 3'd1);
    drain_cdb();
    check_all_regs();

    $display("checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
             check_count, err_count, timeout_count,
             tomasulo_core_inst.core_chk_inst.fail_count);
    if (err_count == 0 && timeout_count == 0 &&
        tomasulo_core_inst.core_chk_inst.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/core_chk.sv
// handshake and common data bus assertions bound into the core top
`timescale 1ns/10ps
`default_nettype none

module core_chk (
  input logic clk,
  input logic rst_n,
  input logic instr_req,
  input logic instr_ack,
  input logic cdb_valid
);

  // count of failed assertions
  int unsigned fail_count = 0;

  // ack only answers a pending request
  ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(instr_ack) |-> $past(instr_req))
    else begin
      $error("instr_ack rose while instr_req was low");
      fail_count++;
    end

  // ack is released only once the sender has dropped req
  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(instr_ack) |-> !$past(instr_req))
    else begin
      $error("instr_ack fell before instr_req was seen low");
      fail_count++;
    end

  // single-cycle broadcast
  cdb_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid |=> !cdb_valid)
    else begin
      $error("cdb_valid held for two cycles");
      fail_count++;
    end

endmodule

bind tomasulo_core core_chk core_chk_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .instr_req (instr_req),
  .instr_ack (instr_ack),
  .cdb_valid (cdb_valid)
);

`default_nettype wire

// File: verilog/tomasulo_core.sv
// top level of the out-of-order add core
`timescale 1ns/10ps
`default_nettype none

module tomasulo_core import isa_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // four-phase instruction intake
  input  logic     instr_req,
  input  instr_t   instr,
  output logic     instr_ack,
  // common data bus, also visible outside
  output logic     cdb_valid,
  output reg_idx_t cdb_dest,
  output data_t    cdb_data,
  // register peek
  input  reg_idx_t dbg_sel,
  output data_t    dbg_data
);

  issue_if    issue_bus ();
  reg_read_if rd_bus ();
  dispatch_if disp_bus ();

  issue_ctrl issue_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .issue     (issue_bus.issuer),
    .rd        (rd_bus.reader)
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue_bus.sink),
    .rd        (rd_bus.file),
    .cdb_valid (cdb_valid),
    .cdb_dest  (cdb_dest),
    .cdb_data  (cdb_data),
    .dbg_sel   (dbg_sel),
    .dbg_data  (dbg_data)
  );

  res_station res_station_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (issue_bus.station),
    .disp      (disp_bus.source),
    .cdb_valid (cdb_valid),
    .cdb_dest  (cdb_dest),
    .cdb_data  (cdb_data)
  );

  add_unit add_unit_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .disp      (disp_bus.unit),
    .cdb_valid (cdb_valid),
    .cdb_dest  (cdb_dest),
    .cdb_data  (cdb_data)
  );

endmodule

`default_nettype wire

// File: verilog/issue_ctrl.sv
// four-phase instruction intake, decode and issue FSM
`timescale 1ns/10ps
`default_nettype none

module issue_ctrl import isa_pkg::*, core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   instr_req,
  input  instr_t instr,
  output logic   instr_ack,
  issue_if.issuer issue,
  reg_read_if.reader rd
);

  issue_state_t state;
  instr_t       instr_q;
  opcode_t      op;
  reg_idx_t     dest;
  logic         is_add;
  logic         can_issue;

  // decode from the latched word, stable through ISSUE
  assign op        = instr_op(instr_q);
  assign dest      = instr_dest(instr_q);
  assign rd.a_idx  = instr_src_a(instr_q);
  assign rd.b_idx  = instr_src_b(instr_q);

  // one producer per register, so wait while dest is still pending
  assign is_add    = (op == ADDF);
  assign can_issue = is_add && !rd.busy[dest] && !issue.full;

  assign issue.valid  = (state == ISSUE) && can_issue;
  assign issue.dest   = dest;
  // value when ready, otherwise the source index is the tag
  assign issue.a_src  = rd.a_idx;
  assign issue.a_val  = rd.a_data;
  assign issue.a_busy = rd.a_busy;
  assign issue.b_src  = rd.b_idx;
  assign issue.b_val  = rd.b_data;
  assign issue.b_busy = rd.b_busy;

  assign instr_ack = (state == ACK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (instr_req) state <= ISSUE;
        // non-add opcodes are dropped and acked right away
        ISSUE: if (!is_add || can_issue) state <= ACK;
        // drop ack once the sender has released req
        ACK: if (!instr_req) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // capture the word when the request is first seen
  always_ff @(posedge clk) begin
    if (state == IDLE && instr_req) begin
      instr_q <= instr;
    end
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// architectural registers with busy bits, forwarding read ports
// and a debug read port
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module reg_file import isa_pkg::*, core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  issue_if.sink    issue,
  reg_read_if.file rd,
  input  logic     cdb_valid,
  input  reg_idx_t cdb_dest,
  input  data_t    cdb_data,
  input  reg_idx_t dbg_sel,
  output data_t    dbg_data
);

  data_t     regs [`NUM_REGS];
  busy_vec_t busy;

  // r0 reads zero, a register on the bus this cycle reads the bus
  function automatic data_t read_data(reg_idx_t idx);
    data_t val;
    if (idx == '0) val = '0;
    else if (cdb_valid && cdb_dest == idx) val = cdb_data;
    else val = regs[idx];
    return val;
  endfunction

  function automatic logic read_busy(reg_idx_t idx);
    return (idx != '0) && busy[idx] && !(cdb_valid && cdb_dest == idx);
  endfunction

  always_comb begin
    rd.a_data = read_data(rd.a_idx);
    rd.b_data = read_data(rd.b_idx);
    rd.a_busy = read_busy(rd.a_idx);
    rd.b_busy = read_busy(rd.b_idx);
  end

  // raw vector, the destination check waits for the write edge
  assign rd.busy = busy;

  assign dbg_data = (dbg_sel == '0) ? '0 : regs[dbg_sel];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= (i == 0) ? '0 : data_t'(`REG_RESET_VAL);
      end
    end else begin
      // write-back from the common data bus
      if (cdb_valid && cdb_dest != '0) begin
        regs[cdb_dest] <= cdb_data;
        busy[cdb_dest] <= 1'b0;
      end
      // new producer, set last so it wins over a same-cycle clear
      if (issue.valid && issue.dest != '0) begin
        busy[issue.dest] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: station/res_station.sv
// add reservation station: entry storage, bus snooping and
// lowest-index ready dispatch
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module res_station import isa_pkg::*, core_pkg::*; #(
  parameter int DEPTH = `RS_DEPTH
) (
  input  logic      clk,
  input  logic      rst_n,
  issue_if.station  issue,
  dispatch_if.source disp,
  input  logic      cdb_valid,
  input  reg_idx_t  cdb_dest,
  input  data_t     cdb_data
);

  // per-entry state
  logic [DEPTH-1:0] in_use;
  logic [DEPTH-1:0] a_rdy;
  logic [DEPTH-1:0] b_rdy;
  reg_idx_t         dest_q [DEPTH];
  reg_idx_t         a_src  [DEPTH];
  reg_idx_t         b_src  [DEPTH];
  data_t            a_val  [DEPTH];
  data_t            b_val  [DEPTH];

  logic [DEPTH-1:0] ready;
  rs_idx_t          free_idx;
  rs_idx_t          disp_idx;

  // both operands captured, from registered state only
  assign ready = in_use & a_rdy & b_rdy;

  assign issue.full = &in_use;

  // lowest free slot and lowest ready slot, scan downward so index 0 wins
  always_comb begin
    free_idx = '0;
    disp_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!in_use[i]) free_idx = rs_idx_t'(i);
      if (ready[i]) disp_idx = rs_idx_t'(i);
    end
  end

  // hold ready entries while the add unit is occupied
  assign disp.valid = |ready && !disp.unit_busy;
  assign disp.dest  = dest_q[disp_idx];
  assign disp.a     = a_val[disp_idx];
  assign disp.b     = b_val[disp_idx];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_use <= '0;
    end else begin
      if (disp.valid) begin
        in_use[disp_idx] <= 1'b0;
      end
      // issue is never raised while full, so free_idx is valid here
      if (issue.valid) begin
        in_use[free_idx] <= 1'b1;
      end
    end
  end

  // operand capture, snoop first, then the new entry
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (in_use[i] && !a_rdy[i] && cdb_valid && cdb_dest == a_src[i]) begin
        a_val[i] <= cdb_data;
        a_rdy[i] <= 1'b1;
      end
      if (in_use[i] && !b_rdy[i] && cdb_valid && cdb_dest == b_src[i]) begin
        b_val[i] <= cdb_data;
        b_rdy[i] <= 1'b1;
      end
    end
    if (issue.valid) begin
      dest_q[free_idx] <= issue.dest;
      a_src[free_idx]  <= issue.a_src;
      b_src[free_idx]  <= issue.b_src;
      // a busy operand keeps its tag and waits for the bus
      a_val[free_idx]  <= issue.a_val;
      b_val[free_idx]  <= issue.b_val;
      a_rdy[free_idx]  <= !issue.a_busy;
      b_rdy[free_idx]  <= !issue.b_busy;
    end
  end

endmodule

`default_nettype wire

// File: exec/add_unit.sv
// add execution unit driving the common data bus
`timescale 1ns/10ps
`default_nettype none

module add_unit import isa_pkg::*, core_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  dispatch_if.unit   disp,
  output logic       cdb_valid,
  output reg_idx_t   cdb_dest,
  output data_t      cdb_data
);

  logic     busy_q;
  logic     done;
  data_t    sum_q;
  reg_idx_t dest_q;

  exec_timer timer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .start (disp.valid),
    .done  (done)
  );

  // busy through the broadcast cycle
  always_ff @(posedge clk) begin
    if (!rst_n) busy_q <= 1'b0;
    else if (disp.valid) busy_q <= 1'b1;
    else if (done) busy_q <= 1'b0;
  end

  // result computed on entry, held until broadcast
  always_ff @(posedge clk) begin
    if (disp.valid) begin
      sum_q  <= disp.a + disp.b;
      dest_q <= disp.dest;
    end
  end

  assign disp.unit_busy = busy_q;
  assign cdb_valid      = done;
  assign cdb_dest       = dest_q;
  assign cdb_data       = sum_q;

endmodule

`default_nettype wire

// File: exec/exec_timer.sv
// down-counter timing one multi-cycle operation
`timescale 1ns/10ps
`default_nettype none

`include "core_defines.svh"

module exec_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic done
);

  localparam int CNT_W = $clog2(`ADD_LATENCY + 1);

  logic [CNT_W-1:0] count;

  // zero means idle
  always_ff @(posedge clk) begin
    if (!rst_n) count <= '0;
    else if (start) count <= CNT_W'(`ADD_LATENCY);
    else if (count != '0) count <= count - 1'b1;
  end

  // last cycle of the count, exactly ADD_LATENCY cycles after start
  assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// File: common/core_ifs.sv
// issue_if, reg_read_if and dispatch_if with their modports
`timescale 1ns/10ps
`default_nettype none

// issue bus from the intake FSM to the station and the register file
interface issue_if import isa_pkg::*, core_pkg::*; ();
  // one-cycle pulse, never while full
  logic     valid;
  reg_idx_t dest;
  // source index doubles as the wait tag
  reg_idx_t a_src;
  data_t    a_val;
  logic     a_busy;
  reg_idx_t b_src;
  data_t    b_val;
  logic     b_busy;
  // all station entries in use
  logic     full;

  modport issuer (output valid, dest, a_src, a_val, a_busy, b_src, b_val, b_busy,
                  input full);
  modport station (input valid, dest, a_src, a_val, a_busy, b_src, b_val, b_busy,
                   output full);
  // register file only needs the destination to mark busy
  modport sink (input valid, dest);
endinterface

// combinational operand reads
interface reg_read_if import isa_pkg::*, core_pkg::*; ();
  reg_idx_t  a_idx;
  reg_idx_t  b_idx;
  data_t     a_data;
  data_t     b_data;
  logic      a_busy;
  logic      b_busy;
  busy_vec_t busy;

  modport reader (output a_idx, b_idx, input a_data, b_data, a_busy, b_busy, busy);
  modport file (input a_idx, b_idx, output a_data, b_data, a_busy, b_busy, busy);
endinterface

// station to add unit
interface dispatch_if import isa_pkg::*, core_pkg::*; ();
  // one-cycle pulse, only while unit_busy is low
  logic     valid;
  reg_idx_t dest;
  data_t    a;
  data_t    b;
  logic     unit_busy;

  modport source (output valid, dest, a, b, input unit_busy);
  modport unit (input valid, dest, a, b, output unit_busy);
endinterface

`default_nettype wire

// File: common/core_pkg.sv
// microarchitecture types: data word, station index, busy vector
// and issue FSM states
`default_nettype none

`include "core_defines.svh"

package core_pkg;

  typedef logic [`DATA_W-1:0] data_t;

  // one busy bit per architectural register
  typedef logic [`NUM_REGS-1:0] busy_vec_t;

  typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

  // intake FSM: wait for req, try to issue, hold ack
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    ACK   = 2'd2
  } issue_state_t;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
// instruction set types: opcode, register index, instruction word
// and field extract helpers
`default_nettype none

package isa_pkg;

  // reference opcode codes, 101..111 are unused and act like NOP
  typedef enum logic [2:0] {
    NOP   = 3'b000,
    LD    = 3'b001,
    ST    = 3'b010,
    ADDF  = 3'b011,
    MULTF = 3'b100
  } opcode_t;

  typedef logic [2:0] reg_idx_t;

  // op[11:9] dest[8:6] src_a[5:3] src_b[2:0]
  typedef logic [11:0] instr_t;

  function automatic opcode_t instr_op(instr_t i);
    return opcode_t'(i[11:9]);
  endfunction

  function automatic reg_idx_t instr_dest(instr_t i);
    return i[8:6];
  endfunction

  function automatic reg_idx_t instr_src_a(instr_t i);
    return i[5:3];
  endfunction

  function automatic reg_idx_t instr_src_b(instr_t i);
    return i[2:0];
  endfunction

endpackage

`default_nettype wire

// File: common/core_defines.svh
// core sizing macros: register count, data width, station depth,
// add latency and register reset value
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// architectural registers, r0 is hardwired zero
`define NUM_REGS 8

// register and common data bus width
`define DATA_W 32

// entries in the add reservation station
`define RS_DEPTH 4

// cycles from dispatch to broadcast on the common data bus
`define ADD_LATENCY 3

// value loaded into r1..r7 at reset
`define REG_RESET_VAL 1

`endif
